//--- asym_fifo_pkg.sv
package asym_fifo_pkg;

   localparam int lane_w_c = 8;  // bits per byte lane

   // registered status, split onto ports at the top level
   typedef struct packed {
      logic w_full;
      logic r_empty;
   } fifo_flags_t;

   function automatic int max_lanes(input int a, input int b);
      return (a > b) ? a : b;
   endfunction

   function automatic int min_lanes(input int a, input int b);
      return (a < b) ? a : b;
   endfunction

   // log2 of wide side over narrow side
   function automatic int ratio_log2(input int w_lanes, input int r_lanes);
      return $clog2(max_lanes(w_lanes, r_lanes) / min_lanes(w_lanes, r_lanes));
   endfunction

   // pointer width of one side, counted in that side's words
   function automatic int ptr_w(input int addr_w, input int side_lanes, input int other_lanes);
      int narrow_w;
      narrow_w = addr_w - $clog2(min_lanes(side_lanes, other_lanes));
      if (side_lanes > other_lanes)
         return narrow_w - ratio_log2(side_lanes, other_lanes);
      return narrow_w;
   endfunction

   // ram rows are as wide as the wider side
   function automatic int row_w(input int addr_w, input int w_lanes, input int r_lanes);
      return addr_w - $clog2(max_lanes(w_lanes, r_lanes));
   endfunction

   function automatic bit valid_lanes(input int lanes);
      return (lanes == 1) || (lanes == 2) || (lanes == 4) || (lanes == 8);
   endfunction

endpackage

//--- fifo_ctrl.sv
`timescale 1ns/1ps

module fifo_ctrl #(
   parameter int W_LANES = 1,
   parameter int R_LANES = 4,
   parameter int ADDR_W = 6,
   localparam int W_PTR_W = asym_fifo_pkg::ptr_w(ADDR_W, W_LANES, R_LANES),
   localparam int R_PTR_W = asym_fifo_pkg::ptr_w(ADDR_W, R_LANES, W_LANES)
) (
   input  logic                        clk_i,
   input  logic                        reset_i,
   input  logic                        w_en_i,
   input  logic                        r_en_i,
   output logic                        w_go_o,
   output logic                        r_go_o,
   output logic [W_PTR_W-1:0]          w_ptr_o,
   output logic [R_PTR_W-1:0]          r_ptr_o,
   output logic [ADDR_W:0]             level_o,
   output asym_fifo_pkg::fifo_flags_t  flags_o
);
   import asym_fifo_pkg::*;

   localparam logic [ADDR_W:0] DEPTH = {1'b1, {ADDR_W{1'b0}}};  // in lanes
   localparam logic [ADDR_W:0] W_INCR = (ADDR_W + 1)'(W_LANES);
   localparam logic [ADDR_W:0] R_INCR = (ADDR_W + 1)'(R_LANES);

   logic [W_PTR_W-1:0] w_ptr_q;
   logic [R_PTR_W-1:0] r_ptr_q;
   logic [ADDR_W:0]    level_q;
   logic [ADDR_W:0]    level_nxt;
   fifo_flags_t        flags_q;
   fifo_flags_t        flags_nxt;

   // accesses while full or empty are dropped here
   assign w_go_o = w_en_i & ~flags_q.w_full;
   assign r_go_o = r_en_i & ~flags_q.r_empty;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         w_ptr_q <= '0;
         r_ptr_q <= '0;
      end else begin
         if (w_go_o)
            w_ptr_q <= w_ptr_q + 1'b1;  // wraps with the row count
         if (r_go_o)
            r_ptr_q <= r_ptr_q + 1'b1;
      end
   end

   always_comb begin
      level_nxt = level_q;
      case ({w_go_o, r_go_o})
         2'b10:   level_nxt = level_q + W_INCR;           // write only
         2'b01:   level_nxt = level_q - R_INCR;           // read only
         2'b11:   level_nxt = level_q + W_INCR - R_INCR;  // both
         default: level_nxt = level_q;
      endcase
   end

   // flags follow the next level so they are right one edge later
   always_comb begin
      flags_nxt.w_full  = level_nxt > (DEPTH - W_INCR);
      flags_nxt.r_empty = level_nxt < R_INCR;
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         level_q         <= '0;
         flags_q.w_full  <= 1'b0;
         flags_q.r_empty <= 1'b1;
      end else begin
         level_q <= level_nxt;
         flags_q <= flags_nxt;
      end
   end

   assign w_ptr_o = w_ptr_q;
   assign r_ptr_o = r_ptr_q;
   assign level_o = level_q;
   assign flags_o = flags_q;

   // depth is at least twice the wider side, so both flags cannot hold
   a_flags_excl: assert property (
      @(posedge clk_i) disable iff (reset_i)
      !(flags_q.w_full && flags_q.r_empty)
   );

   a_level_max: assert property (
      @(posedge clk_i) disable iff (reset_i)
      level_q <= DEPTH
   );

   // no silent drift of the level
   a_level_hold: assert property (
      @(posedge clk_i) disable iff (reset_i)
      !(w_go_o || r_go_o) |=> $stable(level_q)
   );

endmodule

//--- lane_converter.sv
`timescale 1ns/1ps

module lane_converter #(
   parameter int W_LANES = 1,
   parameter int R_LANES = 4,
   parameter int ADDR_W = 6,
   localparam int MAX_LANES = asym_fifo_pkg::max_lanes(W_LANES, R_LANES),
   localparam int ROW_W = asym_fifo_pkg::row_w(ADDR_W, W_LANES, R_LANES),
   localparam int W_PTR_W = asym_fifo_pkg::ptr_w(ADDR_W, W_LANES, R_LANES),
   localparam int R_PTR_W = asym_fifo_pkg::ptr_w(ADDR_W, R_LANES, W_LANES)
) (
   input  logic                                          clk_i,
   input  logic                                          reset_i,
   input  logic                                          w_go_i,
   input  logic                                          r_go_i,
   input  logic [W_PTR_W-1:0]                            w_ptr_i,
   input  logic [R_PTR_W-1:0]                            r_ptr_i,
   input  logic [W_LANES*asym_fifo_pkg::lane_w_c-1:0]    w_data_i,
   output logic [R_LANES*asym_fifo_pkg::lane_w_c-1:0]    r_data_o,
   output logic                                          mem_w_en_o,
   output logic [ROW_W-1:0]                              mem_w_row_o,
   output logic [MAX_LANES-1:0]                          mem_w_mask_o,
   output logic [MAX_LANES*asym_fifo_pkg::lane_w_c-1:0]  mem_w_data_o,
   output logic                                          mem_r_en_o,
   output logic [ROW_W-1:0]                              mem_r_row_o,
   input  logic [MAX_LANES*asym_fifo_pkg::lane_w_c-1:0]  mem_r_data_i
);
   import asym_fifo_pkg::*;

   localparam int SEL_W = ratio_log2(W_LANES, R_LANES);  // narrow words per row, log2
   localparam int R_BITS = R_LANES * lane_w_c;

   assign mem_w_en_o = w_go_i;
   assign mem_r_en_o = r_go_i;

   if (W_LANES < R_LANES) begin : g_narrow_w
      localparam logic [MAX_LANES-1:0] W_BASE_MASK = MAX_LANES'({W_LANES{1'b1}});

      logic [SEL_W-1:0] w_sel;

      assign mem_w_row_o = w_ptr_i[W_PTR_W-1:SEL_W];
      assign w_sel       = w_ptr_i[SEL_W-1:0];

      // same word on every slot, mask picks the slot
      assign mem_w_mask_o = W_BASE_MASK << (w_sel * W_LANES);
      assign mem_w_data_o = {(MAX_LANES / W_LANES){w_data_i}};
   end else begin : g_wide_w
      assign mem_w_row_o  = w_ptr_i;
      assign mem_w_mask_o = '1;  // whole row
      assign mem_w_data_o = w_data_i;
   end

   if (R_LANES < W_LANES) begin : g_narrow_r
      logic [SEL_W-1:0] r_sel_q;

      assign mem_r_row_o = r_ptr_i[R_PTR_W-1:SEL_W];

      // slot index travels alongside the ram read
      always_ff @(posedge clk_i) begin
         if (reset_i)
            r_sel_q <= '0;
         else if (r_go_i)
            r_sel_q <= r_ptr_i[SEL_W-1:0];
      end

      assign r_data_o = mem_r_data_i[r_sel_q * R_BITS +: R_BITS];
   end else begin : g_wide_r
      assign mem_r_row_o = r_ptr_i;
      assign r_data_o    = mem_r_data_i;
   end

   // one write word of lanes per write, a single lane for byte writes
   a_mask_lanes: assert property (
      @(posedge clk_i) disable iff (reset_i)
      mem_w_en_o |-> ($countones(mem_w_mask_o) == W_LANES)
   );

endmodule

//--- lane_ram_2p.sv
`timescale 1ns/1ps

module lane_ram_2p #(
   parameter int LANES = 4,
   parameter int ROW_W = 4
) (
   input  logic                                      clk_i,
   input  logic                                      reset_i,
   input  logic                                      w_en_i,
   input  logic                                      r_en_i,
   input  logic [ROW_W-1:0]                          w_row_i,
   input  logic [ROW_W-1:0]                          r_row_i,
   input  logic [LANES-1:0]                          w_mask_i,
   input  logic [LANES*asym_fifo_pkg::lane_w_c-1:0]  w_data_i,
   output logic [LANES*asym_fifo_pkg::lane_w_c-1:0]  r_data_o
);
   import asym_fifo_pkg::*;

   localparam int ROWS = 2 ** ROW_W;

   logic [LANES*lane_w_c-1:0] mem_q [ROWS];

   always_ff @(posedge clk_i) begin
      if (w_en_i) begin
         for (int l = 0; l < LANES; l++) begin
            if (w_mask_i[l])
               mem_q[w_row_i][l*lane_w_c +: lane_w_c] <= w_data_i[l*lane_w_c +: lane_w_c];
         end
      end
   end

   // holds between reads, old data on a same-row write
   always_ff @(posedge clk_i) begin
      if (reset_i)
         r_data_o <= '0;
      else if (r_en_i)
         r_data_o <= mem_q[r_row_i];
   end

   a_rows_known: assert property (
      @(posedge clk_i) disable iff (reset_i)
      !((w_en_i && $isunknown(w_row_i)) || (r_en_i && $isunknown(r_row_i)))
   );

endmodule

//--- asym_fifo.sv
`timescale 1ns/1ps

module asym_fifo #(
   parameter int W_LANES = 1,
   parameter int R_LANES = 4,
   parameter int ADDR_W = 6
) (
   input  logic                                        clk_i,
   input  logic                                        reset_i,
   input  logic                                        w_en_i,
   input  logic [W_LANES*asym_fifo_pkg::lane_w_c-1:0]  w_data_i,
   input  logic                                        r_en_i,
   output logic [R_LANES*asym_fifo_pkg::lane_w_c-1:0]  r_data_o,
   output logic                                        w_full_o,
   output logic                                        r_empty_o,
   output logic [ADDR_W:0]                             level_o
);
   import asym_fifo_pkg::*;

   localparam int MAX_LANES = max_lanes(W_LANES, R_LANES);
   localparam int ROW_W = row_w(ADDR_W, W_LANES, R_LANES);
   localparam int W_PTR_W = ptr_w(ADDR_W, W_LANES, R_LANES);
   localparam int R_PTR_W = ptr_w(ADDR_W, R_LANES, W_LANES);
   localparam int ROW_BITS = MAX_LANES * lane_w_c;

   // elaboration checks on the shape
   if (!valid_lanes(W_LANES) || !valid_lanes(R_LANES)) begin : g_bad_lanes
      $error("asym_fifo: each side must be 1, 2, 4 or 8 lanes wide");
   end
   if ((min_lanes(W_LANES, R_LANES) << ratio_log2(W_LANES, R_LANES)) != MAX_LANES)
   begin : g_bad_ratio
      $error("asym_fifo: wide side is not a power-of-two multiple of the narrow side");
   end
   if (ADDR_W <= $clog2(MAX_LANES)) begin : g_bad_depth
      $error("asym_fifo: depth must hold at least two wide words");
   end

   fifo_flags_t          flags;
   logic                 w_go;
   logic                 r_go;
   logic [W_PTR_W-1:0]   w_ptr;
   logic [R_PTR_W-1:0]   r_ptr;
   logic                 mem_w_en;
   logic [ROW_W-1:0]     mem_w_row;
   logic [MAX_LANES-1:0] mem_w_mask;
   logic [ROW_BITS-1:0]  mem_w_data;
   logic                 mem_r_en;
   logic [ROW_W-1:0]     mem_r_row;
   logic [ROW_BITS-1:0]  mem_r_data;

   fifo_ctrl #(
      .W_LANES(W_LANES),
      .R_LANES(R_LANES),
      .ADDR_W (ADDR_W)
   ) u_fifo_ctrl (
      .clk_i  (clk_i),
      .reset_i(reset_i),
      .w_en_i (w_en_i),
      .r_en_i (r_en_i),
      .w_go_o (w_go),
      .r_go_o (r_go),
      .w_ptr_o(w_ptr),
      .r_ptr_o(r_ptr),
      .level_o(level_o),
      .flags_o(flags)
   );

   lane_converter #(
      .W_LANES(W_LANES),
      .R_LANES(R_LANES),
      .ADDR_W (ADDR_W)
   ) u_lane_converter (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .w_go_i      (w_go),
      .r_go_i      (r_go),
      .w_ptr_i     (w_ptr),
      .r_ptr_i     (r_ptr),
      .w_data_i    (w_data_i),
      .r_data_o    (r_data_o),
      .mem_w_en_o  (mem_w_en),
      .mem_w_row_o (mem_w_row),
      .mem_w_mask_o(mem_w_mask),
      .mem_w_data_o(mem_w_data),
      .mem_r_en_o  (mem_r_en),
      .mem_r_row_o (mem_r_row),
      .mem_r_data_i(mem_r_data)
   );

   lane_ram_2p #(
      .LANES(MAX_LANES),
      .ROW_W(ROW_W)
   ) u_lane_ram (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .w_en_i  (mem_w_en),
      .r_en_i  (mem_r_en),
      .w_row_i (mem_w_row),
      .r_row_i (mem_r_row),
      .w_mask_i(mem_w_mask),
      .w_data_i(mem_w_data),
      .r_data_o(mem_r_data)
   );

   assign w_full_o  = flags.w_full;
   assign r_empty_o = flags.r_empty;

endmodule

//--- tb_asym_fifo_model.svh
// byte queue model, oldest byte at the front
logic [7:0] byte_q[$];
int         errors = 0;
int         checks = 0;

function automatic logic [31:0] xorshift32(input logic [31:0] x);
   logic [31:0] s;
   s = x;
   s = s ^ (s << 13);
   s = s ^ (s >> 17);
   s = s ^ (s << 5);
   return s;
endfunction

// accepted write, low lane goes in first
function automatic void push_word(input logic [W_BITS-1:0] word);
   for (int l = 0; l < W_LANES; l++)
      byte_q.push_back(word[l*LANE_W +: LANE_W]);
endfunction

// expected read word: the oldest bytes, oldest one in lane 0
function automatic logic [R_BITS-1:0] pop_word();
   logic [R_BITS-1:0] word;
   word = '0;
   for (int l = 0; l < R_LANES; l++)
      word[l*LANE_W +: LANE_W] = byte_q.pop_front();
   return word;
endfunction

function automatic bit full_from_level(input int level);
   return level > (DEPTH_LANES - W_LANES);  // no room for one more write word
endfunction

function automatic bit empty_from_level(input int level);
   return level < R_LANES;  // not a whole read word left
endfunction

task automatic check_value(input string name, input logic [63:0] expected,
                           input logic [63:0] actual);
   checks++;
   if (actual !== expected) begin
      errors++;
      $display("mismatch %s: expected 0x%0h, got 0x%0h at %0t", name, expected, actual, $time);
   end
endtask

//--- tb_asym_fifo.sv
`timescale 1ns/1ps

module tb_asym_fifo #(
   parameter int W_LANES = 1,
   parameter int R_LANES = 4
);

   localparam int ADDR_W = 6;
   localparam int LANE_W = 8;
   localparam int DEPTH_LANES = 2 ** ADDR_W;
   localparam int W_BITS = W_LANES * LANE_W;
   localparam int R_BITS = R_LANES * LANE_W;
   localparam int NUM_OPS = 2000;       // random cycles
   localparam int MODE_LEN = 200;       // cycles per traffic mode
   localparam int TIMEOUT_NS = (NUM_OPS + 300) * 20;
   localparam logic [31:0] SEED = 32'h8002f21f;

   logic              clk_i;
   logic              reset_i;
   logic              w_en_i;
   logic [W_BITS-1:0] w_data_i;
   logic              r_en_i;
   logic [R_BITS-1:0] r_data_o;
   logic              w_full_o;
   logic              r_empty_o;
   logic [ADDR_W:0]   level_o;
   logic [31:0]       rng = SEED;

   `include "tb_asym_fifo_model.svh"

   asym_fifo #(
      .W_LANES(W_LANES),
      .R_LANES(R_LANES),
      .ADDR_W (ADDR_W)
   ) u_asym_fifo (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .w_en_i   (w_en_i),
      .w_data_i (w_data_i),
      .r_en_i   (r_en_i),
      .r_data_o (r_data_o),
      .w_full_o (w_full_o),
      .r_empty_o(r_empty_o),
      .level_o  (level_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #10 clk_i = ~clk_i;
   end

   // one clock of strobes, fresh random data every time
   task automatic drive_cycle(input bit w, input bit r);
      logic [31:0] lo;
      @(posedge clk_i);
      rng = xorshift32(rng);
      lo = rng;
      rng = xorshift32(rng);
      w_en_i   <= w;
      r_en_i   <= r;
      w_data_i <= W_BITS'({rng, lo});
   endtask

   task automatic idle_cycles(input int count);
      repeat (count) drive_cycle(1'b0, 1'b0);
   endtask

   // rates are scaled in lanes so fill mode really fills and drain mode drains
   task automatic random_cycles(input int count);
      int mode;
      bit w;
      bit r;
      for (int i = 0; i < count; i++) begin
         mode = (i / MODE_LEN) % 3;
         rng = xorshift32(rng);
         case (mode)
            0: begin  // fill
               w = (rng[1:0] != 2'b00);
               r = (int'(rng[15:8]) % (4 * R_LANES)) < W_LANES;
            end
            1: begin  // drain
               r = (rng[1:0] != 2'b00);
               w = (int'(rng[15:8]) % (4 * W_LANES)) < R_LANES;
            end
            default: begin
               w = rng[2];
               r = rng[3];
            end
         endcase
         drive_cycle(w, r);
      end
   endtask

   // mid-cycle compare, then book the accesses of the coming edge
   initial begin : compare
      int                lvl;
      bit                exp_full;
      bit                exp_empty;
      logic [R_BITS-1:0] exp_rdata;
      exp_rdata = '0;  // read register resets
      forever begin
         @(negedge clk_i);
         if (!reset_i) begin
            lvl       = byte_q.size();
            exp_full  = full_from_level(lvl);
            exp_empty = empty_from_level(lvl);
            check_value("level_o", 64'(lvl), 64'(level_o));
            check_value("w_full_o", 64'(exp_full), 64'(w_full_o));
            check_value("r_empty_o", 64'(exp_empty), 64'(r_empty_o));
            check_value("r_data_o", 64'(exp_rdata), 64'(r_data_o));
            if (r_en_i && !exp_empty)
               exp_rdata = pop_word();
            if (w_en_i && !exp_full)
               push_word(w_data_i);
         end
      end
   end

   initial begin : stimulus
      reset_i  = 1'b1;
      w_en_i   = 1'b0;
      r_en_i   = 1'b0;
      w_data_i = '0;
      repeat (3) @(posedge clk_i);
      reset_i <= 1'b0;
      idle_cycles(2);

      // fill past full, the surplus writes must vanish
      repeat (DEPTH_LANES / W_LANES + 4) drive_cycle(1'b1, 1'b0);
      idle_cycles(2);
      @(negedge clk_i);
      check_value("w_full_o after fill", 64'(1), 64'(w_full_o));
      check_value("level_o after fill", 64'(DEPTH_LANES), 64'(level_o));

      // drain, then strobe reads on the empty FIFO
      repeat (DEPTH_LANES / R_LANES) drive_cycle(1'b0, 1'b1);
      repeat (3) drive_cycle(1'b0, 1'b1);
      idle_cycles(2);
      @(negedge clk_i);
      check_value("r_empty_o after drain", 64'(1), 64'(r_empty_o));
      check_value("level_o after drain", 64'(0), 64'(level_o));

      random_cycles(NUM_OPS);
      idle_cycles(4);  // last read word still in flight

      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

   initial begin : watchdog
      #(TIMEOUT_NS);
      $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
      $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

//--- asym_fifo.f
+incdir+.
asym_fifo_pkg.sv
fifo_ctrl.sv
lane_converter.sv
lane_ram_2p.sv
asym_fifo.sv
tb_asym_fifo.sv
